// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing --timescale 1ns/1ps -j 0
TOP       = tbMips
FILELIST  = compile.f
LOG       = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
+incdir+.
isaPkg.sv
pipePkg.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
memWriteback.sv
mipsCore.sv
tbMips.sv

// ==== decodeStage.sv ====
`include "mipsDefs.svh"

module decodeStage (
    input  isaPkg::word_t    dInstr,
    input  isaPkg::addr_t    dPc4,
    input  isaPkg::word_t    rfData1,
    input  isaPkg::word_t    rfData2,
    output isaPkg::regAddr_t rfAddr1,
    output isaPkg::regAddr_t rfAddr2,
    input  pipePkg::idEx_t   exFwd,
    input  pipePkg::exMem_t  memFwd,
    output logic             stall,
    output logic             redirect,
    output isaPkg::addr_t    target,
    output pipePkg::idEx_t   idEx
);
    import isaPkg::*;
    import pipePkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    regAddr_t dst;
    shamt_t   shamt;
    imm16_t   imm16;
    ctrl_t    ctrl;
    logic     writes;
    logic     signExt;
    logic     useRs;
    logic     useRt;
    logic     isBeq;
    logic     isBne;
    logic     isJump;
    logic     isJr;
    logic     taken;
    tNew_t    tUseRs;
    tNew_t    tUseRt;
    word_t    rsVal;
    word_t    rtVal;

    assign opcode = dInstr[31:26];
    assign rs = dInstr[25:21];
    assign rt = dInstr[20:16];
    assign rd = dInstr[15:11];
    assign shamt = dInstr[10:6];
    assign funct = dInstr[5:0];
    assign imm16 = dInstr[15:0];
    assign rfAddr1 = rs;
    assign rfAddr2 = rt;

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = ALU_ADD;
        writes = 1'b0;
        dst = rt;
        signExt = 1'b1;
        useRs = 1'b0;
        useRt = 1'b0;
        tUseRs = 2'd1;
        tUseRt = 2'd1;
        isBeq = 1'b0;
        isBne = 1'b0;
        isJump = 1'b0;
        isJr = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                writes = 1'b1;
                dst = rd;
                useRs = 1'b1;
                useRt = 1'b1;
                ctrl.tNew = 2'd1;
                case (funct)
                    FN_ADDU: ctrl.aluOp = ALU_ADD;
                    FN_SUBU: ctrl.aluOp = ALU_SUB;
                    FN_AND:  ctrl.aluOp = ALU_AND;
                    FN_OR:   ctrl.aluOp = ALU_OR;
                    FN_SLT:  ctrl.aluOp = ALU_SLT;
                    FN_SLL: begin
                        ctrl.aluOp = ALU_SLL;
                        useRs = 1'b0;
                    end
                    FN_JR: begin
                        writes = 1'b0;
                        useRt = 1'b0;
                        tUseRs = 2'd0;
                        isJr = 1'b1;
                    end
                    default: begin
                        writes = 1'b0;
                        useRs = 1'b0;
                        useRt = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                writes = 1'b1;
                ctrl.immSel = 1'b1;
                useRs = (opcode != OP_LUI);
                signExt = (opcode != OP_ORI);
                ctrl.memRead = (opcode == OP_LW);
                ctrl.tNew = (opcode == OP_LW) ? 2'd2 : 2'd1;
                ctrl.aluOp = (opcode == OP_ORI) ? ALU_OR :
                             (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
            end
            OP_SW: begin
                ctrl.memWe = 1'b1;
                ctrl.immSel = 1'b1;
                useRs = 1'b1;
                useRt = 1'b1;
                tUseRt = 2'd2;
            end
            OP_BEQ, OP_BNE: begin
                useRs = 1'b1;
                useRt = 1'b1;
                tUseRs = 2'd0;
                tUseRt = 2'd0;
                isBeq = (opcode == OP_BEQ);
                isBne = (opcode == OP_BNE);
            end
            OP_J: isJump = 1'b1;
            OP_JAL: begin
                isJump = 1'b1;
                writes = 1'b1;
                ctrl.isLink = 1'b1;
                dst = `MIPS_LINK_REG;
            end
            default: ;
        endcase
        // Writes to $0 are dropped here, so later stages never see them
        ctrl.regWe = writes && (dst != '0);
    end

    // Only finished results are forwarded, the stall covers the rest
    function automatic fwdSel_e fwdSel(input regAddr_t r);
        if (r == '0) begin
            return FWD_NONE;
        end
        if (exFwd.ctrl.regWe && exFwd.dst == r) begin
            return (exFwd.ctrl.tNew == '0) ? FWD_EX_PC8 : FWD_NONE;
        end
        if (memFwd.regWe && memFwd.dst == r && memFwd.tNew == '0) begin
            return memFwd.isLink ? FWD_MEM_PC8 : FWD_MEM_RESULT;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t fwdValue(input regAddr_t r, input word_t rf);
        case (fwdSel(r))
            FWD_EX_PC8:     return exFwd.pc8;
            FWD_MEM_PC8:    return memFwd.pc8;
            FWD_MEM_RESULT: return memFwd.result;
            default:        return rf;
        endcase
    endfunction

    function automatic logic hazard(input regAddr_t r, input tNew_t tUse);
        if (r == '0) begin
            return 1'b0;
        end
        return (exFwd.ctrl.regWe && exFwd.dst == r && exFwd.ctrl.tNew > tUse) ||
               (memFwd.regWe && memFwd.dst == r && memFwd.tNew > tUse);
    endfunction

    always_comb begin
        rsVal = fwdValue(rs, rfData1);
        rtVal = fwdValue(rt, rfData2);
        stall = (useRs && hazard(rs, tUseRs)) || (useRt && hazard(rt, tUseRt));
    end

    // Branch and jump resolution
    always_comb begin
        taken = (isBeq && rsVal == rtVal) || (isBne && rsVal != rtVal) || isJump || isJr;
        if (isJr) begin
            target = rsVal;
        end else if (isJump) begin
            target = {dPc4[31:28], dInstr[25:0], 2'b00};
        end else begin
            target = dPc4 + {{14{imm16[15]}}, imm16, 2'b00};
        end
        redirect = taken && !stall;
    end

    always_comb begin
        idEx.pc8 = dPc4 + 32'd4;
        idEx.rsVal = rsVal;
        idEx.rtVal = rtVal;
        idEx.imm = signExt ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
        idEx.shamt = shamt;
        idEx.rs = rs;
        idEx.rt = rt;
        idEx.dst = dst;
        idEx.ctrl = ctrl;
        // Bubble into execute
        if (stall) begin
            idEx = '0;
        end
    end

endmodule

// ==== executeStage.sv ====
module executeStage (
    input  logic            clk,
    input  logic            reset,
    input  pipePkg::idEx_t  idEx,
    input  pipePkg::exMem_t memFwd,
    input  pipePkg::memWb_t wbFwd,
    input  isaPkg::word_t   wbData,
    output pipePkg::idEx_t  exView,
    output pipePkg::exMem_t exMem
);
    import isaPkg::*;
    import pipePkg::*;

    word_t rsFwd;
    word_t rtFwd;
    word_t opB;
    word_t result;

    always_ff @(posedge clk) begin
        if (reset) begin
            exView <= '0;
        end else begin
            exView <= idEx;
        end
    end

    // A memory-stage match that is not ready yet hides older writeback values
    function automatic fwdSel_e fwdSel(input regAddr_t r);
        if (r == '0) begin
            return FWD_NONE;
        end
        if (memFwd.regWe && memFwd.dst == r) begin
            if (memFwd.tNew != '0) begin
                return FWD_NONE;
            end
            return memFwd.isLink ? FWD_MEM_PC8 : FWD_MEM_RESULT;
        end
        if (wbFwd.regWe && wbFwd.dst == r && wbFwd.tNew == '0) begin
            return wbFwd.isLink ? FWD_WB_PC8 : FWD_WB_DATA;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t fwdValue(input regAddr_t r, input word_t own);
        case (fwdSel(r))
            FWD_MEM_RESULT: return memFwd.result;
            FWD_MEM_PC8:    return memFwd.pc8;
            FWD_WB_DATA:    return wbData;
            FWD_WB_PC8:     return wbFwd.pc8;
            default:        return own;
        endcase
    endfunction

    always_comb begin
        rsFwd = fwdValue(exView.rs, exView.rsVal);
        rtFwd = fwdValue(exView.rt, exView.rtVal);
        opB = exView.ctrl.immSel ? exView.imm : rtFwd;
        case (exView.ctrl.aluOp)
            ALU_ADD: result = rsFwd + opB;
            ALU_SUB: result = rsFwd - opB;
            ALU_AND: result = rsFwd & opB;
            ALU_OR:  result = rsFwd | opB;
            ALU_SLT: result = ($signed(rsFwd) < $signed(opB)) ? 32'd1 : 32'd0;
            ALU_SLL: result = rtFwd << exView.shamt;
            ALU_LUI: result = {exView.imm[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    always_comb begin
        exMem.pc8 = exView.pc8;
        exMem.result = result;
        exMem.storeData = rtFwd;
        exMem.rt = exView.rt;
        exMem.dst = exView.dst;
        exMem.regWe = exView.ctrl.regWe;
        exMem.memWe = exView.ctrl.memWe;
        exMem.memRead = exView.ctrl.memRead;
        exMem.isLink = exView.ctrl.isLink;
        exMem.tNew = ageTNew(exView.ctrl.tNew);
    end

endmodule

// ==== fetchStage.sv ====
`include "mipsDefs.svh"

module fetchStage (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          redirect,
    input  isaPkg::addr_t target,
    output isaPkg::addr_t instrAddr,
    input  isaPkg::word_t instrData,
    output isaPkg::word_t dInstr,
    output isaPkg::addr_t dPc4
);
    import isaPkg::*;

    addr_t pc;
    addr_t pc4;

    assign pc4 = pc + 32'd4;
    assign instrAddr = pc;

    // The word fetched while decode redirects is the delay slot,
    // so the redirect only changes the following PC
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pc <= redirect ? target : pc4;
        end
    end

    // Decode register, frozen while decode stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            dInstr <= `MIPS_NOP;
            dPc4 <= '0;
        end else if (!stall) begin
            dInstr <= instrData;
            dPc4 <= pc4;
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetch PC %h is not word aligned", pc);

endmodule

// ==== isaPkg.sv ====
package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm16_t;
    typedef logic [4:0]  shamt_t;

    // Major opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_ORI   = 6'h0d;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // Function codes under OP_RTYPE
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } aluOp_e;

endpackage

// ==== memWriteback.sv ====
module memWriteback (
    input  logic               clk,
    input  logic               reset,
    input  pipePkg::exMem_t    exMem,
    output pipePkg::exMem_t    memView,
    output pipePkg::dmemReq_t  dmemReq,
    input  isaPkg::word_t      dmemRdata,
    output pipePkg::memWb_t    wbView,
    output isaPkg::word_t      wbData,
    output pipePkg::regWrite_t regWrite
);
    import isaPkg::*;
    import pipePkg::*;

    word_t storeData;
    logic  wbHit;

    always_ff @(posedge clk) begin
        if (reset) begin
            memView <= '0;
        end else begin
            memView <= exMem;
        end
    end

    // Covers a load retiring right behind the store that uses its value
    assign wbHit = wbView.regWe && wbView.tNew == '0 && wbView.dst == memView.rt;
    assign storeData = wbHit ? wbData : memView.storeData;

    assign dmemReq.addr = memView.result;
    assign dmemReq.wdata = storeData;
    assign dmemReq.we = memView.memWe;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbView <= '0;
        end else begin
            wbView.pc8 <= memView.pc8;
            wbView.result <= memView.result;
            wbView.loadData <= dmemRdata;
            wbView.dst <= memView.dst;
            wbView.regWe <= memView.regWe;
            wbView.memRead <= memView.memRead;
            wbView.isLink <= memView.isLink;
            wbView.tNew <= ageTNew(memView.tNew);
        end
    end

    always_comb begin
        if (wbView.isLink) begin
            wbData = wbView.pc8;
        end else if (wbView.memRead) begin
            wbData = wbView.loadData;
        end else begin
            wbData = wbView.result;
        end
    end

    // Trace reports the PC of the retiring instruction
    assign regWrite.we = wbView.regWe;
    assign regWrite.addr = wbView.dst;
    assign regWrite.data = wbData;
    assign regWrite.pc = wbView.pc8 - 32'd8;

    storeAligned: assert property (@(posedge clk) disable iff (reset)
        dmemReq.we |-> dmemReq.addr[1:0] == 2'b00)
        else $error("store to unaligned address %h", dmemReq.addr);

endmodule

// ==== mipsCore.sv ====
module mipsCore (
    input  logic               clk,
    input  logic               reset,
    output isaPkg::addr_t      instrAddr,
    input  isaPkg::word_t      instrData,
    output pipePkg::dmemReq_t  dmemReq,
    input  isaPkg::word_t      dmemRdata,
    output pipePkg::regWrite_t regWrite
);
    import isaPkg::*;
    import pipePkg::*;

    word_t    dInstr;
    addr_t    dPc4;
    addr_t    target;
    logic     stall;
    logic     redirect;
    regAddr_t rfAddr1;
    regAddr_t rfAddr2;
    word_t    rfData1;
    word_t    rfData2;
    word_t    wbData;
    idEx_t    idEx;
    idEx_t    exView;
    exMem_t   exMem;
    exMem_t   memView;
    memWb_t   wbView;

    fetchStage fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dInstr    (dInstr),
        .dPc4      (dPc4)
    );

    // Written from the trace port, one write per retiring instruction
    regFile regs (
        .clk    (clk),
        .reset  (reset),
        .rAddr1 (rfAddr1),
        .rAddr2 (rfAddr2),
        .rData1 (rfData1),
        .rData2 (rfData2),
        .we     (regWrite.we),
        .wAddr  (regWrite.addr),
        .wData  (regWrite.data)
    );

    decodeStage decode (
        .dInstr   (dInstr),
        .dPc4     (dPc4),
        .rfData1  (rfData1),
        .rfData2  (rfData2),
        .rfAddr1  (rfAddr1),
        .rfAddr2  (rfAddr2),
        .exFwd    (exView),
        .memFwd   (memView),
        .stall    (stall),
        .redirect (redirect),
        .target   (target),
        .idEx     (idEx)
    );

    executeStage execute (
        .clk    (clk),
        .reset  (reset),
        .idEx   (idEx),
        .memFwd (memView),
        .wbFwd  (wbView),
        .wbData (wbData),
        .exView (exView),
        .exMem  (exMem)
    );

    memWriteback memWb (
        .clk       (clk),
        .reset     (reset),
        .exMem     (exMem),
        .memView   (memView),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata),
        .wbView    (wbView),
        .wbData    (wbData),
        .regWrite  (regWrite)
    );

endmodule

// ==== mipsDefs.svh ====
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Boot address of the instruction memory
`define MIPS_RESET_PC 32'h0000_3000

// Encodes sll $0, $0, 0
`define MIPS_NOP 32'h0000_0000

// Destination of jal
`define MIPS_LINK_REG 5'd31

// Architectural general registers
`define MIPS_NUM_REGS 32

`endif

// ==== pipePkg.sv ====
package pipePkg;

    // Cycles until a producer's result can be forwarded
    typedef logic [1:0] tNew_t;

    typedef struct packed {
        logic           regWe;
        logic           memWe;
        logic           memRead;
        logic           isLink;
        logic           immSel;
        isaPkg::aluOp_e aluOp;
        tNew_t          tNew;
    } ctrl_t;

    typedef struct packed {
        isaPkg::addr_t    pc8;
        isaPkg::word_t    rsVal;
        isaPkg::word_t    rtVal;
        isaPkg::word_t    imm;
        isaPkg::shamt_t   shamt;
        isaPkg::regAddr_t rs;
        isaPkg::regAddr_t rt;
        isaPkg::regAddr_t dst;
        ctrl_t            ctrl;
    } idEx_t;

    typedef struct packed {
        isaPkg::addr_t    pc8;
        isaPkg::word_t    result;
        isaPkg::word_t    storeData;
        isaPkg::regAddr_t rt;
        isaPkg::regAddr_t dst;
        logic             regWe;
        logic             memWe;
        logic             memRead;
        logic             isLink;
        tNew_t            tNew;
    } exMem_t;

    typedef struct packed {
        isaPkg::addr_t    pc8;
        isaPkg::word_t    result;
        isaPkg::word_t    loadData;
        isaPkg::regAddr_t dst;
        logic             regWe;
        logic             memRead;
        logic             isLink;
        tNew_t            tNew;
    } memWb_t;

    typedef struct packed {
        isaPkg::addr_t addr;
        isaPkg::word_t wdata;
        logic          we;
    } dmemReq_t;

    typedef struct packed {
        logic             we;
        isaPkg::regAddr_t addr;
        isaPkg::word_t    data;
        isaPkg::addr_t    pc;
    } regWrite_t;

    typedef enum logic [2:0] {
        FWD_NONE,
        FWD_MEM_RESULT,
        FWD_MEM_PC8,
        FWD_EX_PC8,
        FWD_WB_DATA,
        FWD_WB_PC8
    } fwdSel_e;

    // One stage older means one cycle closer to the result
    function automatic tNew_t ageTNew(input tNew_t t);
        return (t != '0) ? t - 2'd1 : '0;
    endfunction

endpackage

// ==== regFile.sv ====
`include "mipsDefs.svh"

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  isaPkg::regAddr_t rAddr1,
    input  isaPkg::regAddr_t rAddr2,
    output isaPkg::word_t    rData1,
    output isaPkg::word_t    rData2,
    input  logic             we,
    input  isaPkg::regAddr_t wAddr,
    input  isaPkg::word_t    wData
);
    import isaPkg::*;

    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    // Write-first, so decode sees the value retiring this cycle
    function automatic word_t readPort(input regAddr_t a);
        if (a == '0) begin
            return '0;
        end
        if (we && a == wAddr) begin
            return wData;
        end
        return regs[a];
    endfunction

    always_comb begin
        rData1 = readPort(rAddr1);
        rData2 = readPort(rAddr2);
    end

endmodule

// ==== tbMips.sv ====
`include "mipsDefs.svh"

module tbMips;
    timeunit 1ns;
    timeprecision 1ps;

    import isaPkg::*;
    import pipePkg::*;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } store_t;

    logic      clk;
    logic      reset;
    addr_t     instrAddr;
    word_t     instrData;
    dmemReq_t  dmemReq;
    word_t     dmemRdata;
    regWrite_t regWrite;

    word_t     imem [256];
    word_t     dram [64];
    word_t     prog [$];
    word_t     modelRegs [`MIPS_NUM_REGS];
    word_t     modelMem [64];
    addr_t     modelPc;
    addr_t     modelNpc;
    regWrite_t expWrites [$];
    store_t    expStores [$];
    logic      active;
    logic      resetSeen;
    int        errors;
    int        checks;
    int        tests;
    int        totalSteps;
    int        cycles;
    logic      timedOut;

    mipsCore uut (
        .clk       (clk),
        .reset     (reset),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .dmemReq   (dmemReq),
        .dmemRdata (dmemRdata),
        .regWrite  (regWrite)
    );

    always #4 clk = ~clk;

    function automatic word_t fetchWord(input addr_t a);
        addr_t off;
        off = (a - `MIPS_RESET_PC) >> 2;
        return (off < 256) ? imem[off[7:0]] : `MIPS_NOP;
    endfunction

    // Both memories answer in the same cycle
    always_comb begin
        instrData = fetchWord(instrAddr);
        dmemRdata = dram[dmemReq.addr[7:2]];
    end

    always @(posedge clk) begin
        if (dmemReq.we) begin
            dram[dmemReq.addr[7:2]] <= dmemReq.wdata;
        end
    end

    function automatic word_t encR(input funct_t fn, input int rs, input int rt,
                                   input int rd, input int sh);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic word_t encI(input opcode_t op, input int rs, input int rt,
                                   input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // Jump to the instruction at a program index
    function automatic word_t encJ(input opcode_t op, input int idx);
        addr_t a;
        a = `MIPS_RESET_PC + idx * 4;
        return {op, a[27:2]};
    endfunction

    // ISA model of one instruction, with the delay slot held in modelNpc
    function automatic regWrite_t refStep();
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     se;
        word_t     ea;
        addr_t     nextNpc;
        regWrite_t w;
        store_t    s;
        ins = fetchWord(modelPc);
        a = modelRegs[ins[25:21]];
        b = modelRegs[ins[20:16]];
        se = {{16{ins[15]}}, ins[15:0]};
        ea = a + se;
        w = '0;
        w.pc = modelPc;
        w.addr = ins[20:16];
        nextNpc = modelNpc + 32'd4;
        case (ins[31:26])
            OP_RTYPE: begin
                w.we = 1'b1;
                w.addr = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: w.data = a + b;
                    FN_SUBU: w.data = a - b;
                    FN_AND:  w.data = a & b;
                    FN_OR:   w.data = a | b;
                    FN_SLT:  w.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLL:  w.data = b << ins[10:6];
                    FN_JR: begin
                        w.we = 1'b0;
                        nextNpc = a;
                    end
                    default: w.we = 1'b0;
                endcase
            end
            OP_ADDIU: {w.we, w.data} = {1'b1, ea};
            OP_ORI:   {w.we, w.data} = {1'b1, a | {16'h0000, ins[15:0]}};
            OP_LUI:   {w.we, w.data} = {1'b1, ins[15:0], 16'h0000};
            OP_LW:    {w.we, w.data} = {1'b1, modelMem[ea[7:2]]};
            OP_SW: begin
                modelMem[ea[7:2]] = b;
                s.addr = ea;
                s.data = b;
                expStores.push_back(s);
            end
            OP_BEQ: if (a == b) nextNpc = modelPc + 32'd4 + (se << 2);
            OP_BNE: if (a != b) nextNpc = modelPc + 32'd4 + (se << 2);
            OP_J:   nextNpc = {modelNpc[31:28], ins[25:0], 2'b00};
            OP_JAL: begin
                nextNpc = {modelNpc[31:28], ins[25:0], 2'b00};
                w.we = 1'b1;
                w.addr = `MIPS_LINK_REG;
                w.data = modelPc + 32'd8;
            end
            default: ;
        endcase
        if (w.we && w.addr != '0) begin
            modelRegs[w.addr] = w.data;
        end else begin
            w.we = 1'b0;
        end
        modelPc = modelNpc;
        modelNpc = nextNpc;
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // High once a clock edge has applied reset to the core
    always @(posedge clk) begin
        resetSeen <= reset;
    end

    // Compares the trace port and the store requests with the model
    always @(negedge clk) begin
        regWrite_t ew;
        store_t    es;
        if (resetSeen) begin
            checkValue("instrAddr", instrAddr, `MIPS_RESET_PC);
            checkValue("regWrite.we", regWrite.we, 0);
            checkValue("dmemReq.we", dmemReq.we, 0);
        end else if (active) begin
            if (regWrite.we) begin
                if (expWrites.size() == 0) begin
                    errors++;
                    $display("Unexpected write to register %0d from pc %h",
                             regWrite.addr, regWrite.pc);
                end else begin
                    ew = expWrites.pop_front();
                    checkValue("regWrite.addr", regWrite.addr, ew.addr);
                    checkValue("regWrite.data", regWrite.data, ew.data);
                    checkValue("regWrite.pc", regWrite.pc, ew.pc);
                end
            end
            if (dmemReq.we) begin
                if (expStores.size() == 0) begin
                    errors++;
                    $display("Unexpected store to address %h", dmemReq.addr);
                end else begin
                    es = expStores.pop_front();
                    checkValue("dmemReq.addr", dmemReq.addr, es.addr);
                    checkValue("dmemReq.wdata", dmemReq.wdata, es.data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Budget grows with every program that is prepared
    initial begin
        timedOut = 1'b0;
        while (!timedOut) begin
            @(posedge clk);
            if (cycles > totalSteps * 8 + tests * 64 + 100) begin
                timedOut = 1'b1;
            end
        end
        $display("Watchdog expired after %0d cycles, the core stopped retiring", cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic runTest(input string name);
        regWrite_t w;
        addr_t     loopPc;
        int        steps;
        int        errBefore;
        int        nWrites;
        @(posedge clk);
        #1;
        reset = 1'b1;
        active = 1'b0;
        errBefore = errors;
        // Self-jump loop with a NOP in its delay slot
        loopPc = `MIPS_RESET_PC + prog.size() * 4;
        prog.push_back(encJ(OP_J, prog.size()));
        prog.push_back(`MIPS_NOP);
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : `MIPS_NOP;
        end
        for (int i = 0; i < 64; i++) begin
            dram[i] = (i * 4 * 32'h9e37_79b9) ^ (i * 4) ^ 32'ha5a5_0000;
            modelMem[i] = dram[i];
        end
        for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = `MIPS_RESET_PC;
        modelNpc = `MIPS_RESET_PC + 32'd4;
        steps = 0;
        while (modelPc != loopPc && steps < 1000) begin
            w = refStep();
            if (w.we) begin
                expWrites.push_back(w);
            end
            steps++;
        end
        nWrites = expWrites.size();
        totalSteps += steps;
        tests++;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        active = 1'b1;
        while (expWrites.size() != 0 || expStores.size() != 0) begin
            @(posedge clk);
        end
        // Catch writes that should never appear
        repeat (12) @(posedge clk);
        prog.delete();
        $display("Test %s: %s, %0d writes", name,
                 (errors == errBefore) ? "ok" : "mismatch", nWrites);
    endtask

    task automatic buildRandom(input int len);
        int kind;
        int rs;
        int rt;
        int rd;
        for (int i = 0; i < len; i++) begin
            kind = $urandom_range(10, 0);
            rs = $urandom_range(7, 0);
            rt = $urandom_range(7, 0);
            rd = $urandom_range(7, 1);
            case (kind)
                0: prog.push_back(encR(FN_ADDU, rs, rt, rd, 0));
                1: prog.push_back(encR(FN_SUBU, rs, rt, rd, 0));
                2: prog.push_back(encR(FN_AND, rs, rt, rd, 0));
                3: prog.push_back(encR(FN_OR, rs, rt, rd, 0));
                4: prog.push_back(encR(FN_SLT, rs, rt, rd, 0));
                5: prog.push_back(encR(FN_SLL, 0, rt, rd, $urandom_range(31, 0)));
                6: prog.push_back(encI(OP_ADDIU, rs, rd, $urandom_range(65535, 0)));
                7: prog.push_back(encI(OP_ORI, rs, rd, $urandom_range(65535, 0)));
                8: prog.push_back(encI(OP_LUI, 0, rd, $urandom_range(65535, 0)));
                9: prog.push_back(encI(OP_LW, 0, rd, $urandom_range(15, 0) * 4));
                default: prog.push_back(encI(OP_SW, 0, rt, $urandom_range(15, 0) * 4));
            endcase
        end
    endtask

    initial begin
        void'($urandom(32'h823b_81b1));
        clk = 1'b0;
        reset = 1'b1;
        active = 1'b0;
        errors = 0;
        checks = 0;
        tests = 0;
        totalSteps = 0;
        cycles = 0;

        runTest("reset");

        prog = '{encI(OP_ADDIU, 0, 1, 5), encI(OP_ADDIU, 1, 2, 3),
                 encR(FN_ADDU, 1, 2, 3, 0), encR(FN_SUBU, 3, 1, 4, 0),
                 encR(FN_AND, 4, 3, 5, 0), encR(FN_OR, 5, 2, 6, 0),
                 encR(FN_SLT, 4, 3, 7, 0), encR(FN_SLT, 3, 4, 8, 0),
                 encR(FN_SLL, 0, 3, 9, 4), encI(OP_LUI, 0, 10, 16'h1234),
                 encI(OP_ORI, 10, 10, 16'h5678), encR(FN_ADDU, 10, 10, 11, 0),
                 encR(FN_SUBU, 0, 11, 12, 0), encR(FN_SLT, 12, 0, 13, 0)};
        runTest("alu forwarding");

        prog = '{encI(OP_ADDIU, 0, 1, 8), encI(OP_LW, 1, 2, 0),
                 encR(FN_ADDU, 2, 2, 3, 0), encI(OP_SW, 1, 3, 4),
                 encI(OP_LW, 1, 4, 4), encI(OP_SW, 0, 4, 12),
                 encI(OP_LW, 0, 5, 12), encI(OP_LW, 0, 6, 16),
                 encI(OP_SW, 0, 6, 20), encI(OP_ADDIU, 5, 7, 1),
                 encI(OP_SW, 1, 7, 0), encI(OP_LW, 1, 8, 0),
                 encI(OP_LW, 8, 9, 0)};
        prog[12] = encI(OP_LW, 0, 9, 20);
        runTest("load store");

        prog = '{encI(OP_ADDIU, 0, 1, 3), encI(OP_ADDIU, 0, 2, 3),
                 encI(OP_BEQ, 1, 2, 2), encI(OP_ADDIU, 0, 3, 1),
                 encI(OP_ADDIU, 0, 4, 99), encI(OP_ADDIU, 0, 5, 7),
                 encI(OP_BNE, 5, 1, 2), encI(OP_ADDIU, 5, 6, 1),
                 encI(OP_ADDIU, 0, 4, 98), encI(OP_BEQ, 6, 1, 2),
                 encI(OP_ADDIU, 0, 7, 11), encI(OP_ADDIU, 0, 8, 12),
                 encJ(OP_JAL, 17), encI(OP_ADDIU, 31, 9, 13),
                 encI(OP_ADDIU, 31, 10, 0), encJ(OP_J, 21),
                 encI(OP_ADDIU, 10, 12, 1), encI(OP_ADDIU, 31, 11, 4),
                 encR(FN_JR, 31, 0, 0, 0), encR(FN_ADDU, 11, 9, 13, 0),
                 encI(OP_ADDIU, 0, 4, 97)};
        runTest("control flow");

        for (int n = 0; n < 3; n++) begin
            buildRandom(40);
            runTest($sformatf("random %0d", n));
        end

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
